// File: source/icache_cfg.svh
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// byte address space seen by the core and by L2
`define ICACHE_ADDR_W 19

// address split, from the top: tag, set, word, byte
`define ICACHE_TAG_W 10
`define ICACHE_SET_W 3
`define ICACHE_WORD_W 4

// associativity
`define ICACHE_WAYS 4

// instruction word
`define ICACHE_DATA_W 32

// one L2 beat per word, 64-byte line
`define ICACHE_LINE_BEATS 16

`endif

// File: source/icache_pkg.sv
`default_nettype none

`include "icache_cfg.svh"

package icache_pkg;

    // main cache FSM
    typedef enum logic [2:0] {
        SLEEP    = 3'd0,
        READY    = 3'd1,
        COMPARE  = 3'd2,
        MISS_REQ = 3'd3,
        REFILL   = 3'd4
    } icache_state_e;

    // full byte address
    typedef logic [`ICACHE_ADDR_W-1:0] fetch_addr_t;

    // address fields
    typedef logic [`ICACHE_TAG_W-1:0]  tag_t;
    typedef logic [`ICACHE_SET_W-1:0]  set_idx_t;
    typedef logic [`ICACHE_WORD_W-1:0] word_idx_t;

    // one bit per way
    typedef logic [`ICACHE_WAYS-1:0] way_onehot_t;

    typedef logic [`ICACHE_DATA_W-1:0] word_t;

endpackage

`default_nettype wire

// File: source/fetch_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_cfg.svh"

module fetch_ctrl (
    input  wire logic                    clk,
    input  wire logic                    rst_n,

    input  wire logic                    fetch_req,
    input  wire icache_pkg::fetch_addr_t fetch_addr,
    output logic                         fetch_gnt,
    output icache_pkg::word_t            fetch_r_data,
    output logic                         fetch_r_valid,

    input  wire logic                    icache_work_en,
    input  wire logic                    icache_sleep_en,

    output logic                         rd_en,
    output icache_pkg::set_idx_t         set_idx,
    output icache_pkg::word_idx_t        word_idx,
    output icache_pkg::tag_t             cmp_tag,
    output icache_pkg::way_onehot_t      wr_way,
    output logic                         wr_en,
    output logic                         flush,
    input  wire icache_pkg::way_onehot_t hit_way,
    input  wire icache_pkg::word_t       hit_data,
    input  wire icache_pkg::way_onehot_t set_valid,

    input  wire icache_pkg::way_onehot_t victim,
    output logic                         plru_access,
    output icache_pkg::way_onehot_t      plru_way,

    output logic                         refill_start,
    output icache_pkg::fetch_addr_t      refill_base,
    input  wire logic                    beat_valid,
    input  wire icache_pkg::word_idx_t   beat_idx,
    input  wire icache_pkg::word_t       beat_data,
    input  wire logic                    refill_last
);

    import icache_pkg::*;

    localparam int WORD_LSB = `ICACHE_ADDR_W - `ICACHE_TAG_W - `ICACHE_SET_W - `ICACHE_WORD_W;
    localparam int SET_LSB  = WORD_LSB + `ICACHE_WORD_W;
    localparam int TAG_LSB  = SET_LSB + `ICACHE_SET_W;

    icache_state_e state_q, state_d;
    fetch_addr_t   addr_q;
    way_onehot_t   miss_way_q;
    way_onehot_t   fill_way;
    way_onehot_t   free_way;
    logic          sleep_pend_q;
    logic          sleep_req;
    word_idx_t     addr_word;

    assign sleep_req = icache_sleep_en | sleep_pend_q;
    assign addr_word = addr_q[SET_LSB-1:WORD_LSB];

    // sleep request waits until the FSM is back in READY
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sleep_pend_q <= 1'b0;
        end else if (state_q == READY) begin
            sleep_pend_q <= 1'b0;
        end else if (icache_sleep_en) begin
            sleep_pend_q <= 1'b1;
        end
    end

    // lowest invalid way, else the tree victim
    always_comb begin
        free_way = '0;
        for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
            if (!set_valid[w]) begin
                free_way = way_onehot_t'(1) << w;
            end
        end
        fill_way = (&set_valid) ? victim : free_way;
    end

    // array addressing: new fetch in READY, held address otherwise
    assign set_idx     = (state_q == READY) ? fetch_addr[TAG_LSB-1:SET_LSB] : addr_q[TAG_LSB-1:SET_LSB];
    assign word_idx    = (state_q == READY) ? fetch_addr[SET_LSB-1:WORD_LSB] : beat_idx;
    assign cmp_tag     = addr_q[`ICACHE_ADDR_W-1:TAG_LSB];
    assign refill_base = {addr_q[`ICACHE_ADDR_W-1:SET_LSB], {SET_LSB{1'b0}}};

    always_comb begin
        state_d       = state_q;
        fetch_gnt     = 1'b0;
        fetch_r_valid = 1'b0;
        fetch_r_data  = '0;
        rd_en         = 1'b0;
        wr_en         = 1'b0;
        wr_way        = miss_way_q;
        flush         = 1'b0;
        plru_access   = 1'b0;
        plru_way      = hit_way;
        refill_start  = 1'b0;

        case (state_q)
            SLEEP: begin
                if (icache_work_en) begin
                    state_d = READY;
                end
            end
            READY: begin
                if (sleep_req) begin
                    flush   = 1'b1;
                    state_d = SLEEP;
                end else if (fetch_req) begin
                    fetch_gnt = 1'b1;
                    rd_en     = 1'b1;
                    state_d   = COMPARE;
                end
            end
            COMPARE: begin
                if (|hit_way) begin
                    fetch_r_valid = 1'b1;
                    fetch_r_data  = hit_data;
                    plru_access   = 1'b1;
                    state_d       = READY;
                end else begin
                    state_d = MISS_REQ;
                end
            end
            MISS_REQ: begin
                refill_start = 1'b1;
                state_d      = REFILL;
            end
            REFILL: begin
                if (beat_valid) begin
                    wr_en = 1'b1;
                    // critical word goes straight to the core
                    if (beat_idx == addr_word) begin
                        fetch_r_valid = 1'b1;
                        fetch_r_data  = beat_data;
                    end
                end
                if (refill_last) begin
                    plru_access = 1'b1;
                    plru_way    = miss_way_q;
                    state_d     = READY;
                end
            end
            default: begin
                state_d = SLEEP;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= SLEEP;
            miss_way_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == COMPARE && !(|hit_way)) begin
                miss_way_q <= fill_way;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_gnt) begin
            addr_q <= fetch_addr;
        end
    end

    a_gnt_in_ready: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_gnt |-> state_q == READY);

    a_wr_way_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> $onehot(wr_way));

endmodule

`default_nettype wire

// File: source/way_store.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_cfg.svh"

module way_store (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    rd_en,
    input  wire icache_pkg::set_idx_t    set_idx,
    input  wire icache_pkg::word_idx_t   word_idx,
    input  wire icache_pkg::tag_t        cmp_tag,
    input  wire icache_pkg::way_onehot_t wr_way,
    input  wire logic                    wr_en,
    input  wire icache_pkg::word_t       wr_data,
    input  wire logic                    line_done,
    input  wire logic                    flush,
    output icache_pkg::way_onehot_t      hit_way,
    output icache_pkg::word_t            hit_data,
    output icache_pkg::way_onehot_t      set_valid
);

    import icache_pkg::*;

    localparam int SETS  = 1 << `ICACHE_SET_W;
    localparam int DEPTH = SETS * `ICACHE_LINE_BEATS;

    logic [SETS-1:0][`ICACHE_WAYS-1:0] valid_q;
    logic                              rd_q;
    set_idx_t                          rd_set_q;
    word_t                             way_word [`ICACHE_WAYS];
    tag_t                              way_tag  [`ICACHE_WAYS];

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        word_t data_mem [DEPTH];
        tag_t  tag_mem  [SETS];
        word_t rd_word_q;
        tag_t  rd_tag_q;

        // tag is rewritten with every refill word of the line
        always_ff @(posedge clk) begin
            if (wr_en && wr_way[w]) begin
                data_mem[{set_idx, word_idx}] <= wr_data;
                tag_mem[set_idx]              <= cmp_tag;
            end
            if (rd_en) begin
                rd_word_q <= data_mem[{set_idx, word_idx}];
                rd_tag_q  <= tag_mem[set_idx];
            end
        end

        assign way_word[w] = rd_word_q;
        assign way_tag[w]  = rd_tag_q;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_q     <= 1'b0;
            rd_set_q <= '0;
        end else begin
            rd_q <= rd_en;
            if (rd_en) begin
                rd_set_q <= set_idx;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (flush) begin
            valid_q <= '0;
        end else if (line_done) begin
            valid_q[set_idx] <= valid_q[set_idx] | wr_way;
        end
    end

    assign set_valid = valid_q[rd_set_q];

    // parallel compare, only meaningful the cycle after a read
    always_comb begin
        hit_way  = '0;
        hit_data = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            hit_way[w] = rd_q & set_valid[w] & (way_tag[w] == cmp_tag);
            if (hit_way[w]) begin
                hit_data = hit_data | way_word[w];
            end
        end
    end

    a_hit_onehot0: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(hit_way));

endmodule

`default_nettype wire

// File: source/plru_tree.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_cfg.svh"

module plru_tree (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    access,
    input  wire icache_pkg::set_idx_t    access_set,
    input  wire icache_pkg::way_onehot_t access_way,
    input  wire logic                    flush,
    input  wire icache_pkg::set_idx_t    lookup_set,
    output icache_pkg::way_onehot_t      victim
);

    localparam int SETS = 1 << `ICACHE_SET_W;

    // b0 picks the pair, b1 and b2 the way inside each pair
    logic [SETS-1:0] b0_q;
    logic [SETS-1:0] b1_q;
    logic [SETS-1:0] b2_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            b0_q <= '0;
            b1_q <= '0;
            b2_q <= '0;
        end else if (flush) begin
            b0_q <= '0;
            b1_q <= '0;
            b2_q <= '0;
        end else if (access) begin
            if (access_way[0] | access_way[1]) begin
                // point away from the touched pair and way
                b0_q[access_set] <= 1'b1;
                b1_q[access_set] <= access_way[0];
            end else begin
                b0_q[access_set] <= 1'b0;
                b2_q[access_set] <= access_way[2];
            end
        end
    end

    always_comb begin
        if (!b0_q[lookup_set]) begin
            victim = b1_q[lookup_set] ? 4'b0010 : 4'b0001;
        end else begin
            victim = b2_q[lookup_set] ? 4'b1000 : 4'b0100;
        end
    end

endmodule

`default_nettype wire

// File: source/refill_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_cfg.svh"

module refill_ctrl (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    refill_start,
    input  wire icache_pkg::fetch_addr_t refill_base,

    output logic                         pri_cache_refill_req,
    input  wire logic                    pri_cache_refill_gnt,
    output icache_pkg::fetch_addr_t      pri_cache_refill_addr,
    input  wire logic                    pri_cache_refill_r_valid,
    input  wire icache_pkg::word_t       pri_cache_refill_r_data,
    output logic                         refill_done,

    output logic                         beat_valid,
    output icache_pkg::word_idx_t        beat_idx,
    output icache_pkg::word_t            beat_data
);

    import icache_pkg::*;

    localparam word_idx_t LAST_BEAT = word_idx_t'(`ICACHE_LINE_BEATS - 1);

    logic      busy_q;
    word_idx_t beat_cnt_q;

    // beats count in address order from word 0
    assign beat_valid  = busy_q & pri_cache_refill_r_valid;
    assign beat_idx    = beat_cnt_q;
    assign beat_data   = pri_cache_refill_r_data;
    assign refill_done = beat_valid & (beat_cnt_q == LAST_BEAT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pri_cache_refill_req <= 1'b0;
            busy_q               <= 1'b0;
            beat_cnt_q           <= '0;
        end else if (refill_start) begin
            pri_cache_refill_req <= 1'b1;
            busy_q               <= 1'b1;
            beat_cnt_q           <= '0;
        end else begin
            // request held until L2 grants it
            if (pri_cache_refill_req && pri_cache_refill_gnt) begin
                pri_cache_refill_req <= 1'b0;
            end
            if (beat_valid) begin
                beat_cnt_q <= beat_cnt_q + 1'b1;
                if (beat_cnt_q == LAST_BEAT) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (refill_start) begin
            pri_cache_refill_addr <= refill_base;
        end
    end

    a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
        refill_start |-> !busy_q);

endmodule

`default_nettype wire

// File: source/icache_top.sv
`timescale 1ns/100ps
`default_nettype none

module icache_top (
    input  wire logic                    clk,
    input  wire logic                    rst_n,

    // core side
    input  wire logic                    fetch_req,
    input  wire icache_pkg::fetch_addr_t fetch_addr,
    output logic                         fetch_gnt,
    output icache_pkg::word_t            fetch_r_data,
    output logic                         fetch_r_valid,

    // L2 side
    output logic                         pri_cache_refill_req,
    input  wire logic                    pri_cache_refill_gnt,
    output icache_pkg::fetch_addr_t      pri_cache_refill_addr,
    input  wire logic                    pri_cache_refill_r_valid,
    input  wire icache_pkg::word_t       pri_cache_refill_r_data,
    output logic                         refill_done,

    // power control
    input  wire logic                    icache_work_en,
    input  wire logic                    icache_sleep_en
);

    import icache_pkg::*;

    // way store access from the FSM
    logic        rd_en;
    logic        wr_en;
    set_idx_t    set_idx;
    word_idx_t   word_idx;
    tag_t        cmp_tag;
    way_onehot_t wr_way;
    way_onehot_t hit_way;
    word_t       hit_data;
    way_onehot_t set_valid;
    logic        flush;

    // replacement
    logic        plru_access;
    way_onehot_t plru_way;
    way_onehot_t victim;

    // refill path
    logic        refill_start;
    fetch_addr_t refill_base;
    logic        beat_valid;
    word_idx_t   beat_idx;
    word_t       beat_data;

    fetch_ctrl u_fetch_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .fetch_req       (fetch_req),
        .fetch_addr      (fetch_addr),
        .fetch_gnt       (fetch_gnt),
        .fetch_r_data    (fetch_r_data),
        .fetch_r_valid   (fetch_r_valid),
        .icache_work_en  (icache_work_en),
        .icache_sleep_en (icache_sleep_en),
        .rd_en           (rd_en),
        .set_idx         (set_idx),
        .word_idx        (word_idx),
        .cmp_tag         (cmp_tag),
        .wr_way          (wr_way),
        .wr_en           (wr_en),
        .flush           (flush),
        .hit_way         (hit_way),
        .hit_data        (hit_data),
        .set_valid       (set_valid),
        .victim          (victim),
        .plru_access     (plru_access),
        .plru_way        (plru_way),
        .refill_start    (refill_start),
        .refill_base     (refill_base),
        .beat_valid      (beat_valid),
        .beat_idx        (beat_idx),
        .beat_data       (beat_data),
        .refill_last     (refill_done)
    );

    way_store u_way_store (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_en     (rd_en),
        .set_idx   (set_idx),
        .word_idx  (word_idx),
        .cmp_tag   (cmp_tag),
        .wr_way    (wr_way),
        .wr_en     (wr_en),
        .wr_data   (beat_data),
        .line_done (refill_done),
        .flush     (flush),
        .hit_way   (hit_way),
        .hit_data  (hit_data),
        .set_valid (set_valid)
    );

    // access and lookup both follow the FSM's current set
    plru_tree u_plru_tree (
        .clk        (clk),
        .rst_n      (rst_n),
        .access     (plru_access),
        .access_set (set_idx),
        .access_way (plru_way),
        .flush      (flush),
        .lookup_set (set_idx),
        .victim     (victim)
    );

    refill_ctrl u_refill_ctrl (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .refill_start             (refill_start),
        .refill_base              (refill_base),
        .pri_cache_refill_req     (pri_cache_refill_req),
        .pri_cache_refill_gnt     (pri_cache_refill_gnt),
        .pri_cache_refill_addr    (pri_cache_refill_addr),
        .pri_cache_refill_r_valid (pri_cache_refill_r_valid),
        .pri_cache_refill_r_data  (pri_cache_refill_r_data),
        .refill_done              (refill_done),
        .beat_valid               (beat_valid),
        .beat_idx                 (beat_idx),
        .beat_data                (beat_data)
    );

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
    output logic clk
);

    // 20 ns period
    localparam int HALF_PERIOD = 10;

    logic clk_q = 1'b0;

    always #HALF_PERIOD clk_q = ~clk_q;

    assign clk = clk_q;

endmodule

`default_nettype wire

// File: testbench/l2_model.sv
`timescale 1ns/100ps
`default_nettype none

module l2_model (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    req,
    input  wire icache_pkg::fetch_addr_t addr,
    output logic                         gnt,
    output logic                         r_valid,
    output icache_pkg::word_t            r_data
);

    import icache_pkg::*;

    localparam int    GNT_DELAY = 2;
    localparam word_t DATA_KEY  = 32'hc0de_0000;

    logic        gnt_q   = 1'b0;
    logic        valid_q = 1'b0;
    word_t       data_q  = '0;
    logic        busy_q  = 1'b0;
    fetch_addr_t base_q  = '0;
    logic [4:0]  beat_q  = '0;
    int          wait_q  = 0;
    int          gap_q   = 0;

    // outputs change on the falling edge only
    always @(negedge clk) begin
        gnt_q   <= 1'b0;
        valid_q <= 1'b0;
        if (!rst_n) begin
            busy_q <= 1'b0;
            wait_q <= 0;
            gap_q  <= 0;
            beat_q <= '0;
        end else if (!busy_q) begin
            // grant after a short stall
            if (req && !gnt_q) begin
                if (wait_q == GNT_DELAY) begin
                    gnt_q  <= 1'b1;
                    busy_q <= 1'b1;
                    base_q <= addr;
                    beat_q <= '0;
                    gap_q  <= 1;
                    wait_q <= 0;
                end else begin
                    wait_q <= wait_q + 1;
                end
            end
        end else if (gap_q != 0) begin
            gap_q <= gap_q - 1;
        end else begin
            valid_q <= 1'b1;
            // word address of the beat, mixed with the key
            data_q  <= {15'd0, base_q[18:6], beat_q[3:0]} ^ DATA_KEY;
            gap_q   <= (int'(beat_q) * 5 + int'(base_q[8:6])) % 3;
            beat_q  <= beat_q + 5'd1;
            if (beat_q == 5'd15) begin
                busy_q <= 1'b0;
            end
        end
    end

    assign gnt     = gnt_q;
    assign r_valid = valid_q;
    assign r_data  = data_q;

endmodule

`default_nettype wire

// File: testbench/icache_tb.sv
`timescale 1ns/100ps
`default_nettype none

module icache_tb;

    import icache_pkg::*;

    localparam word_t    L2_KEY      = 32'hc0de_0000;
    localparam set_idx_t FIRST_SET   = 3'd2;
    localparam set_idx_t REPL_SET    = 3'd5;
    localparam int       GNT_LIMIT   = 200;
    localparam int       RESP_LIMIT  = 200;
    localparam int       SLEEP_CHECK = 20;
    localparam int       LINE_BEATS  = 16;

    logic        clk;
    logic        rst_n;
    logic        fetch_req;
    fetch_addr_t fetch_addr;
    logic        fetch_gnt;
    word_t       fetch_r_data;
    logic        fetch_r_valid;
    logic        pri_cache_refill_req;
    logic        pri_cache_refill_gnt;
    fetch_addr_t pri_cache_refill_addr;
    logic        pri_cache_refill_r_valid;
    word_t       pri_cache_refill_r_data;
    logic        refill_done;
    logic        icache_work_en;
    logic        icache_sleep_en;

    int          seed;
    int          mismatches;
    int          other_errors;
    tag_t        first_tag;

    // reference tree bits for the replacement set
    logic        m_b0;
    logic        m_b1;
    logic        m_b2;

    tb_clock u_clock (
        .clk (clk)
    );

    l2_model u_l2 (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (pri_cache_refill_req),
        .addr    (pri_cache_refill_addr),
        .gnt     (pri_cache_refill_gnt),
        .r_valid (pri_cache_refill_r_valid),
        .r_data  (pri_cache_refill_r_data)
    );

    icache_top UUT (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .fetch_req                (fetch_req),
        .fetch_addr               (fetch_addr),
        .fetch_gnt                (fetch_gnt),
        .fetch_r_data             (fetch_r_data),
        .fetch_r_valid            (fetch_r_valid),
        .pri_cache_refill_req     (pri_cache_refill_req),
        .pri_cache_refill_gnt     (pri_cache_refill_gnt),
        .pri_cache_refill_addr    (pri_cache_refill_addr),
        .pri_cache_refill_r_valid (pri_cache_refill_r_valid),
        .pri_cache_refill_r_data  (pri_cache_refill_r_data),
        .refill_done              (refill_done),
        .icache_work_en           (icache_work_en),
        .icache_sleep_en          (icache_sleep_en)
    );

    function automatic fetch_addr_t make_addr(input tag_t t, input set_idx_t s,
                                              input word_idx_t w);
        return {t, s, w, 2'b00};
    endfunction

    // L2 content: word address xor key
    function automatic word_t expected_word(input fetch_addr_t a);
        return {15'd0, a[18:2]} ^ L2_KEY;
    endfunction

    function automatic fetch_addr_t line_base(input fetch_addr_t a);
        return {a[18:6], 6'd0};
    endfunction

    task automatic touch_model(input int way);
        if (way < 2) begin
            m_b0 = 1'b1;
            m_b1 = (way == 0);
        end else begin
            m_b0 = 1'b0;
            m_b2 = (way == 2);
        end
    endtask

    function automatic int predict_victim();
        if (!m_b0) begin
            return m_b1 ? 1 : 0;
        end
        return m_b2 ? 3 : 2;
    endfunction

    task automatic check_word(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s returned %h, expected %h",
                     $time, what, actual, expected);
            mismatches++;
        end
    endtask

    task automatic check_addr(input fetch_addr_t actual, input fetch_addr_t expected,
                              input string what);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s is %h, expected %h",
                     $time, what, actual, expected);
            mismatches++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        other_errors++;
    endtask

    // called just after a falling edge with fetch_req already driven
    task automatic wait_gnt(input int limit, output bit got);
        int i;
        got = 1'b0;
        for (i = 0; i < limit && !got; i++) begin
            if (i > 0) begin
                @(negedge clk);
            end
            #5;
            got = fetch_gnt;
        end
    endtask

    task automatic collect_response(input fetch_addr_t addr, input bit exp_miss,
                                    input string what);
        int cycles;
        int resp_cycles;
        int beats;
        bit saw_req;
        bit saw_last;
        bit done;
        cycles      = 0;
        resp_cycles = 0;
        beats       = 0;
        saw_req     = 1'b0;
        saw_last    = 1'b0;
        done        = 1'b0;
        // a miss is followed until its line refill has completed
        while (!(done && (saw_last || !saw_req)) && cycles < RESP_LIMIT) begin
            @(negedge clk);
            fetch_req = 1'b0;
            #5;
            cycles++;
            if (pri_cache_refill_req && !saw_req) begin
                saw_req = 1'b1;
                check_addr(pri_cache_refill_addr, line_base(addr),
                           $sformatf("%s refill address", what));
            end
            if (pri_cache_refill_r_valid) begin
                beats++;
            end
            if (refill_done) begin
                saw_last = 1'b1;
                if (!pri_cache_refill_r_valid || beats != LINE_BEATS) begin
                    report_error($sformatf("%s refill_done was not on the last beat", what));
                end
            end
            if (fetch_r_valid) begin
                if (done) begin
                    report_error($sformatf("%s returned a second response", what));
                end else begin
                    done        = 1'b1;
                    resp_cycles = cycles;
                    check_word(fetch_r_data, expected_word(addr), what);
                end
            end
        end
        if (!done) begin
            report_error($sformatf("%s got no fetch response in time", what));
        end else if (saw_req != exp_miss) begin
            report_error($sformatf("%s should have been a %s", what, exp_miss ? "miss" : "hit"));
        end else if (!exp_miss && resp_cycles != 1) begin
            report_error($sformatf("%s hit returned after %0d cycles", what, resp_cycles));
        end else if (exp_miss && !saw_last) begin
            report_error($sformatf("%s refill never signalled refill_done", what));
        end
        @(negedge clk);
    endtask

    task automatic do_fetch(input fetch_addr_t addr, input bit exp_miss, input string what);
        bit got;
        fetch_req  = 1'b1;
        fetch_addr = addr;
        wait_gnt(GNT_LIMIT, got);
        if (!got) begin
            report_error($sformatf("%s was never granted", what));
            @(negedge clk);
            fetch_req = 1'b0;
        end else begin
            collect_response(addr, exp_miss, what);
        end
    endtask

    task automatic pulse_sleep();
        icache_sleep_en = 1'b1;
        @(negedge clk);
        icache_sleep_en = 1'b0;
    endtask

    task automatic pulse_work();
        icache_work_en = 1'b1;
        @(negedge clk);
        icache_work_en = 1'b0;
    endtask

    task automatic cold_miss_refill();
        logic [31:0] rnd;
        rnd       = $random(seed);
        first_tag = rnd[9:0];
        do_fetch(make_addr(first_tag, FIRST_SET, 4'd9), 1'b1, "cold miss");
    endtask

    task automatic same_line_hits();
        do_fetch(make_addr(first_tag, FIRST_SET, 4'd3), 1'b0, "same line hit");
        do_fetch(make_addr(first_tag, FIRST_SET, 4'd15), 1'b0, "last word hit");
    endtask

    task automatic plru_replacement();
        tag_t        tags [5];
        int          order [3];
        logic [31:0] rnd;
        bit          dup;
        int          victim;
        int          i;
        int          j;
        for (i = 0; i < 5; i++) begin
            do begin
                rnd     = $random(seed);
                tags[i] = rnd[9:0];
                dup     = 1'b0;
                for (j = 0; j < i; j++) begin
                    if (tags[j] == tags[i]) begin
                        dup = 1'b1;
                    end
                end
            end while (dup);
        end
        m_b0 = 1'b0;
        m_b1 = 1'b0;
        m_b2 = 1'b0;
        // empty set fills ways 0 to 3 in order
        for (i = 0; i < 4; i++) begin
            do_fetch(make_addr(tags[i], REPL_SET, word_idx_t'(i * 3)), 1'b1, "set fill");
            touch_model(i);
        end
        order = '{3, 0, 2};
        for (i = 0; i < 3; i++) begin
            do_fetch(make_addr(tags[order[i]], REPL_SET, 4'd5), 1'b0, "reuse hit");
            touch_model(order[i]);
        end
        victim = predict_victim();
        do_fetch(make_addr(tags[4], REPL_SET, 4'd1), 1'b1, "fifth tag");
        touch_model(victim);
        for (i = 0; i < 4; i++) begin
            if (i != victim) begin
                do_fetch(make_addr(tags[i], REPL_SET, 4'd8), 1'b0, "survivor hit");
                touch_model(i);
            end
        end
        do_fetch(make_addr(tags[victim], REPL_SET, 4'd8), 1'b1, "evicted line");
    endtask

    task automatic sleep_flush_miss();
        fetch_addr_t addr;
        addr = make_addr(first_tag, FIRST_SET, 4'd3);
        do_fetch(addr, 1'b0, "hit before sleep");
        pulse_sleep();
        pulse_work();
        do_fetch(addr, 1'b1, "fetch after flush");
    endtask

    task automatic sleep_blocks_fetch();
        fetch_addr_t addr;
        bit          got;
        addr = make_addr(first_tag, FIRST_SET, 4'd12);
        do_fetch(addr, 1'b0, "hit before block");
        pulse_sleep();
        fetch_req  = 1'b1;
        fetch_addr = addr;
        wait_gnt(SLEEP_CHECK, got);
        if (got) begin
            report_error("fetch was granted while the cache was asleep");
        end
        @(negedge clk);
        // request stays up across the wake pulse
        pulse_work();
        wait_gnt(GNT_LIMIT, got);
        if (!got) begin
            report_error("held fetch was not granted after wake");
            @(negedge clk);
            fetch_req = 1'b0;
        end else begin
            collect_response(addr, 1'b1, "fetch held over sleep");
        end
    endtask

    initial begin
        seed            = 32'h9e62_d4ba;
        mismatches      = 0;
        other_errors    = 0;
        rst_n           = 1'b0;
        fetch_req       = 1'b0;
        fetch_addr      = '0;
        icache_work_en  = 1'b0;
        icache_sleep_en = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        pulse_work();

        cold_miss_refill();
        same_line_hits();
        plru_replacement();
        sleep_flush_miss();
        sleep_blocks_fetch();

        $display("icache_tb finished: %0d mismatches, %0d other errors",
                 mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: icache.f
+incdir+source
source/icache_pkg.sv
source/fetch_ctrl.sv
source/way_store.sv
source/plru_tree.sv
source/refill_ctrl.sv
source/icache_top.sv
testbench/tb_clock.sv
testbench/l2_model.sv
testbench/icache_tb.sv

// File: run.sh
#!/bin/sh
# build the cache and testbench with Verilator, run, then look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timescale 1ns/100ps -j 0 \
    --top-module icache_tb -o icache_sim -f icache.f || exit 1
out="$(./obj_dir/icache_sim)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "TEST PASS" && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
